/* verilog/rv_pkg.sv */
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  mask_t;
	typedef logic [9:0]  inst_class_t;
	typedef logic [3:0]  alu_op_t;

	// bit positions in inst_class_t
	localparam int INST_LUI   = 0;
	localparam int INST_AUIPC = 1;
	localparam int INST_JAL   = 2;
	localparam int INST_JALR  = 3;
	localparam int INST_BEQ   = 4; // all branches
	localparam int INST_LW    = 5; // all loads
	localparam int INST_SW    = 6; // all stores
	localparam int INST_ADDI  = 7;
	localparam int INST_ADD   = 8;
	localparam int INST_CSR   = 9; // whole SYSTEM opcode

	localparam alu_op_t OP_ADD   = 4'd0;
	localparam alu_op_t OP_SUB   = 4'd1;
	localparam alu_op_t OP_AND   = 4'd2;
	localparam alu_op_t OP_XOR   = 4'd3;
	localparam alu_op_t OP_OR    = 4'd4;
	localparam alu_op_t OP_SRL   = 4'd5;
	localparam alu_op_t OP_SRA   = 4'd6;
	localparam alu_op_t OP_SLL   = 4'd7;
	localparam alu_op_t OP_LESS  = 4'd8;
	localparam alu_op_t OP_ULESS = 4'd9;

	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	localparam word_t CAUSE_ECALL_M = 32'd11; // environment call from M-mode
	localparam word_t RESET_PC      = 32'h8000_0000;

endpackage

/* verilog/rv_idu.sv */
`timescale 1ns/10ps

module rv_idu import rv_pkg::*; (
	input  word_t       inst,
	output inst_class_t inst_class,
	output reg_idx_t    rd,
	output reg_idx_t    rs1,
	output reg_idx_t    rs2,
	output word_t       imm,
	output logic [2:0]  funct3,
	output logic [6:0]  funct7,
	output logic [11:0] csr_addr,
	output logic        is_ecall,
	output logic        is_mret,
	output logic        rd_wen
);

	logic [6:0] opcode;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	assign opcode   = inst[6:0];
	assign rd       = inst[11:7];
	assign rs1      = inst[19:15];
	assign rs2      = inst[24:20];
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign csr_addr = inst[31:20];

	always_comb begin
		inst_class = '0;
		case (opcode)
			7'b0110111: inst_class[INST_LUI]   = 1'b1;
			7'b0010111: inst_class[INST_AUIPC] = 1'b1;
			7'b1101111: inst_class[INST_JAL]   = 1'b1;
			7'b1100111: inst_class[INST_JALR]  = 1'b1;
			7'b1100011: inst_class[INST_BEQ]   = 1'b1;
			7'b0000011: inst_class[INST_LW]    = 1'b1;
			7'b0100011: inst_class[INST_SW]    = 1'b1;
			7'b0010011: inst_class[INST_ADDI]  = 1'b1;
			7'b0110011: inst_class[INST_ADD]   = 1'b1;
			7'b1110011: inst_class[INST_CSR]   = 1'b1;
			default: ; // unknown opcode retires as a nop
		endcase
	end

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		imm = imm_i; // jalr, loads, op-imm, system
		if (inst_class[INST_SW])
			imm = imm_s;
		else if (inst_class[INST_BEQ])
			imm = imm_b;
		else if (inst_class[INST_LUI] | inst_class[INST_AUIPC])
			imm = imm_u;
		else if (inst_class[INST_JAL])
			imm = imm_j;
	end

	// privileged ops share funct3 == 0 inside SYSTEM
	assign is_ecall = inst_class[INST_CSR] & (funct3 == 3'b000) & (csr_addr == 12'h000);
	assign is_mret  = inst_class[INST_CSR] & (funct3 == 3'b000) & (csr_addr == 12'h302);

	assign rd_wen = inst_class[INST_LUI] | inst_class[INST_AUIPC] | inst_class[INST_JAL] |
		inst_class[INST_JALR] | inst_class[INST_LW] | inst_class[INST_ADDI] |
		inst_class[INST_ADD] | (inst_class[INST_CSR] & (funct3 != 3'b000));

	a_priv_known: assert final (!(inst_class[INST_CSR] && funct3 == 3'b000) ||
		is_ecall || is_mret)
		else $error("unsupported privileged instruction: %h", inst);

endmodule

/* verilog/rv_exu.sv */
`timescale 1ns/10ps

module rv_exu import rv_pkg::*; (
	input  inst_class_t opcode_type,
	input  word_t       src1,
	input  word_t       src2,
	input  word_t       imm,
	input  word_t       pc,
	input  word_t       csr_val,
	input  logic [2:0]  funct3,
	input  logic [6:0]  funct7,
	output word_t       val,
	output word_t       csr_wdata,
	output logic        jump_en,
	output mask_t       wmask
);

	word_t       lhs;
	word_t       rhs;
	alu_op_t     op;
	logic [32:0] diff;
	logic        lt_s;
	logic [4:0]  shamt;
	logic [32:0] br_diff;
	logic        br_ne;
	logic        br_lt_s;
	logic        br_lt_u;
	logic        taken;

	// register-based address or operand, else pc-relative
	assign lhs = (opcode_type[INST_ADDI] | opcode_type[INST_ADD] | opcode_type[INST_JALR] |
		opcode_type[INST_LW] | opcode_type[INST_SW]) ? src1 :
		opcode_type[INST_LUI] ? '0 : pc;
	assign rhs = opcode_type[INST_ADD] ? src2 : imm;

	always_comb begin
		op = OP_ADD; // address and link arithmetic
		if (opcode_type[INST_ADDI] | opcode_type[INST_ADD]) begin
			case (funct3)
				3'b000: op = (opcode_type[INST_ADD] & funct7[5]) ? OP_SUB : OP_ADD;
				3'b001: op = OP_SLL;
				3'b010: op = OP_LESS;
				3'b011: op = OP_ULESS;
				3'b100: op = OP_XOR;
				3'b101: op = funct7[5] ? OP_SRA : OP_SRL;
				3'b110: op = OP_OR;
				3'b111: op = OP_AND;
			endcase
		end
	end

	assign diff  = {1'b0, lhs} - {1'b0, rhs}; // bit 32 is the borrow
	assign lt_s  = (lhs[31] & ~rhs[31]) | (~(lhs[31] ^ rhs[31]) & diff[31]);
	assign shamt = rhs[4:0];

	always_comb begin
		case (op)
			OP_ADD:   val = lhs + rhs;
			OP_SUB:   val = diff[31:0];
			OP_AND:   val = lhs & rhs;
			OP_XOR:   val = lhs ^ rhs;
			OP_OR:    val = lhs | rhs;
			OP_SRL:   val = lhs >> shamt;
			OP_SRA:   val = $signed(lhs) >>> shamt;
			OP_SLL:   val = lhs << shamt;
			OP_LESS:  val = {31'b0, lt_s};
			OP_ULESS: val = {31'b0, diff[32]};
			default:  val = '0;
		endcase
	end

	// branch compare on the raw register operands
	assign br_diff = {1'b0, src1} - {1'b0, src2};
	assign br_ne   = |br_diff[31:0];
	assign br_lt_u = br_diff[32];
	assign br_lt_s = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & br_diff[31]);

	always_comb begin
		case (funct3)
			3'b000:  taken = ~br_ne;
			3'b001:  taken = br_ne;
			3'b100:  taken = br_lt_s;
			3'b101:  taken = ~br_lt_s;
			3'b110:  taken = br_lt_u;
			3'b111:  taken = ~br_lt_u;
			default: taken = 1'b0;
		endcase
	end

	assign jump_en = opcode_type[INST_JAL] | opcode_type[INST_JALR] |
		(opcode_type[INST_BEQ] & taken);

	always_comb begin
		case (funct3[1:0])
			2'b00:   wmask = 4'b0001;
			2'b01:   wmask = 4'b0011;
			2'b10:   wmask = 4'b1111;
			default: wmask = 4'b0000;
		endcase
	end

	assign csr_wdata = (funct3 == 3'b010) ? (src1 | csr_val) : // csrrs
		(funct3 == 3'b001) ? src1 : '0;                          // csrrw

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  reg_idx_t    rs1,
	input  reg_idx_t    rs2,
	input  reg_idx_t    rd,
	input  logic        rd_wen,
	input  inst_class_t inst_class,
	input  word_t       val,
	input  word_t       load_val,
	input  word_t       csr_val,
	input  word_t       pc,
	output word_t       src1,
	output word_t       src2
);

	word_t regs [32];
	word_t wb_val;

	assign wb_val = inst_class[INST_LW] ? load_val :
		(inst_class[INST_JAL] | inst_class[INST_JALR]) ? pc + 32'd4 : // link
		inst_class[INST_CSR] ? csr_val : val;

	always_ff @(posedge clk) begin
		if (reset)
			regs[0] <= '0; // x0 only ever holds this
		else if (rd_wen && rd != '0)
			regs[rd] <= wb_val;
	end

	assign src1 = regs[rs1];
	assign src2 = regs[rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (reset) (rs1 == '0) |-> (src1 == '0))
		else $error("x0 read back nonzero");

endmodule

/* verilog/rv_csr.sv */
`timescale 1ns/10ps

module rv_csr import rv_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        csr_en,
	input  logic        is_ecall,
	input  logic        is_mret,
	input  logic [2:0]  funct3,
	input  logic [11:0] csr_addr,
	input  word_t       csr_wdata,
	input  word_t       pc,
	output word_t       csr_val,
	output word_t       trap_pc,
	output logic        trap_en
);

	word_t mstatus;
	word_t mtvec;
	word_t mepc;
	word_t mcause;
	logic  csr_write;

	always_comb begin
		case (csr_addr)
			CSR_MSTATUS: csr_val = mstatus;
			CSR_MTVEC:   csr_val = mtvec;
			CSR_MEPC:    csr_val = mepc;
			CSR_MCAUSE:  csr_val = mcause;
			default:     csr_val = '0;
		endcase
	end

	assign csr_write = csr_en & ((funct3 == 3'b001) | (funct3 == 3'b010)); // csrrw, csrrs
	assign trap_en   = csr_en & (is_ecall | is_mret);
	assign trap_pc   = is_ecall ? mtvec : mepc;

	always_ff @(posedge clk) begin
		if (reset) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (is_ecall) begin
			mepc   <= pc;
			mcause <= CAUSE_ECALL_M;
		end else if (csr_write) begin
			case (csr_addr)
				CSR_MSTATUS: mstatus <= csr_wdata;
				CSR_MTVEC:   mtvec   <= csr_wdata;
				CSR_MEPC:    mepc    <= csr_wdata;
				CSR_MCAUSE:  mcause  <= csr_wdata;
				default: ; // unimplemented csr drops the write
			endcase
		end
	end

endmodule

/* verilog/rv_lsu.sv */
`timescale 1ns/10ps

module rv_lsu import rv_pkg::*; (
	input  logic        reset,
	input  inst_class_t inst_class,
	input  logic [2:0]  funct3,
	input  word_t       addr,
	input  word_t       store_data,
	input  mask_t       wmask,
	output word_t       mem_addr,
	output word_t       mem_wdata,
	output logic        mem_wen,
	output mask_t       mem_wmask,
	input  word_t       mem_rdata,
	output word_t       load_val
);

	logic [1:0] offset;
	logic [4:0] lane_shift;
	word_t      rdata_sh;

	assign offset     = addr[1:0];
	assign lane_shift = {offset, 3'b000}; // byte offset in bits

	assign mem_addr  = {addr[31:2], 2'b00};
	assign mem_wdata = store_data << lane_shift;
	assign mem_wmask = mask_t'(wmask << offset);
	assign mem_wen   = inst_class[INST_SW] & ~reset;

	// addressed byte or half moved down to lane 0
	assign rdata_sh = mem_rdata >> lane_shift;

	always_comb begin
		case (funct3)
			3'b000:  load_val = {{24{rdata_sh[7]}}, rdata_sh[7:0]};   // lb
			3'b001:  load_val = {{16{rdata_sh[15]}}, rdata_sh[15:0]}; // lh
			3'b100:  load_val = {24'b0, rdata_sh[7:0]};               // lbu
			3'b101:  load_val = {16'b0, rdata_sh[15:0]};              // lhu
			default: load_val = mem_rdata;
		endcase
	end

	a_store_mask: assert final (!mem_wen || mem_wmask != '0)
		else $error("store issued with empty byte mask at %h", addr);

endmodule

/* verilog/rv_ifu.sv */
`timescale 1ns/10ps

module rv_ifu import rv_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  trap_en,
	input  logic  jump_en,
	input  word_t trap_pc,
	input  word_t jump_target,
	output word_t pc
);

	word_t pc_next;

	always_comb begin
		if (trap_en)
			pc_next = trap_pc; // ecall or mret wins
		else if (jump_en)
			pc_next = {jump_target[31:1], 1'b0};
		else
			pc_next = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	output word_t pc,
	input  word_t inst,
	output word_t mem_addr,
	output logic  mem_wen,
	output word_t mem_wdata,
	output mask_t mem_wmask,
	input  word_t mem_rdata
);

	inst_class_t inst_class;
	reg_idx_t    rd;
	reg_idx_t    rs1;
	reg_idx_t    rs2;
	word_t       imm;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] csr_addr;
	logic        is_ecall;
	logic        is_mret;
	logic        rd_wen;
	word_t       src1;
	word_t       src2;
	word_t       val;
	logic        jump_en;
	word_t       csr_wdata;
	mask_t       wmask;
	word_t       load_val;
	word_t       csr_val;
	logic        trap_en;
	word_t       trap_pc;

	rv_idu u_idu (
		.inst(inst), .inst_class(inst_class), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.funct3(funct3), .funct7(funct7), .csr_addr(csr_addr),
		.is_ecall(is_ecall), .is_mret(is_mret), .rd_wen(rd_wen)
	);

	rv_regfile u_regfile (
		.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .rd_wen(rd_wen),
		.inst_class(inst_class), .val(val), .load_val(load_val), .csr_val(csr_val),
		.pc(pc), .src1(src1), .src2(src2)
	);

	rv_exu u_exu (
		.opcode_type(inst_class), .src1(src1), .src2(src2), .imm(imm), .pc(pc),
		.csr_val(csr_val), .funct3(funct3), .funct7(funct7), .val(val),
		.csr_wdata(csr_wdata), .jump_en(jump_en), .wmask(wmask)
	);

	rv_lsu u_lsu (
		.reset(reset), .inst_class(inst_class), .funct3(funct3), .addr(val),
		.store_data(src2), .wmask(wmask), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wen(mem_wen), .mem_wmask(mem_wmask), .mem_rdata(mem_rdata), .load_val(load_val)
	);

	rv_csr u_csr (
		.clk(clk), .reset(reset), .csr_en(inst_class[INST_CSR]), .is_ecall(is_ecall),
		.is_mret(is_mret), .funct3(funct3), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
		.pc(pc), .csr_val(csr_val), .trap_pc(trap_pc), .trap_en(trap_en)
	);

	rv_ifu u_ifu (
		.clk(clk), .reset(reset), .trap_en(trap_en), .jump_en(jump_en),
		.trap_pc(trap_pc), .jump_target(val), .pc(pc)
	);

endmodule

/* tb/rv_core_tb.sv */
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*; ();

	logic  clk;
	logic  reset;
	word_t inst;
	word_t pc;
	word_t mem_addr;
	logic  mem_wen;
	word_t mem_wdata;
	mask_t mem_wmask;
	word_t mem_rdata;

	word_t  dmem [128]; // bytes 0x000 to 0x1ff
	integer seed;
	word_t  ld_word;
	bit     finished;

	// one row per instruction word, indexed by (pc - RESET_PC) / 4
	word_t prog_inst [$];
	word_t next_pc [$];
	logic  exp_st [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	mask_t exp_mask [$];

	rv_core DUT (
		.clk(clk), .reset(reset), .pc(pc), .inst(inst), .mem_addr(mem_addr),
		.mem_wen(mem_wen), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	assign mem_rdata = dmem[mem_addr[8:2]];

	always @(posedge clk) begin
		if (mem_wen === 1'b1) begin
			for (int b = 0; b < 4; b++)
				if (mem_wmask[b])
					dmem[mem_addr[8:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
		end
	end

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_mask(input string what, input mask_t got, input mask_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	function automatic word_t r_inst(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t i_inst(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_inst(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
		logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_inst(logic [12:0] imm, logic [2:0] f3, reg_idx_t rs1,
		reg_idx_t rs2);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t u_inst(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic word_t j_inst(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t csr_inst(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
		logic [11:0] addr);
		return i_inst(7'b1110011, f3, rd, rs1, addr);
	endfunction

	function automatic bit branch_rule(logic [2:0] f3, word_t x, word_t y);
		case (f3)
			3'b000:  return x == y;
			3'b001:  return x != y;
			3'b100:  return $signed(x) < $signed(y);
			3'b101:  return $signed(x) >= $signed(y);
			3'b110:  return x < y;
			default: return x >= y;
		endcase
	endfunction

	function automatic word_t load_expect(logic [2:0] f3, word_t w);
		logic signed [7:0]  sbyte;
		logic signed [15:0] shalf;
		sbyte = w[7:0];
		shalf = w[15:0];
		case (f3)
			3'b000:  return sbyte; // sign extends on assignment
			3'b001:  return shalf;
			3'b100:  return {24'b0, w[7:0]};
			3'b101:  return {16'b0, w[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic word_t fill_word(word_t addr);
		return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic word_t here();
		return RESET_PC + 32'(prog_inst.size() * 4);
	endfunction

	task automatic put_row(input word_t ins, input word_t nxt, input logic st,
		input word_t addr, input word_t data, input mask_t mask);
		prog_inst.push_back(ins);
		next_pc.push_back(nxt);
		exp_st.push_back(st);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_mask.push_back(mask);
	endtask

	task automatic plain(input word_t ins);
		put_row(ins, here() + 32'd4, 1'b0, '0, '0, '0);
	endtask

	task automatic skip_rows(input int n);
		for (int i = 0; i < n; i++)
			plain(i_inst(7'b0010011, 3'b000, 5'd0, 5'd0, 12'h000)); // nop
	endtask

	task automatic store_word(input reg_idx_t rs, input word_t value);
		put_row(s_inst(3'b010, 5'd0, rs, 12'h100), here() + 32'd4, 1'b1, 32'h100, value, 4'hf);
	endtask

	task automatic alu_case(input logic [6:0] f7, input logic [2:0] f3, input word_t result);
		plain(r_inst(f7, f3, 5'd5, 5'd3, 5'd4)); // x5 = x3 op x4
		store_word(5'd5, result);
	endtask

	task automatic branch_case(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
		input word_t v1, input word_t v2);
		word_t at;
		at = here();
		put_row(b_inst(13'd8, f3, rs1, rs2), branch_rule(f3, v1, v2) ? at + 32'd8 : at + 32'd4,
			1'b0, '0, '0, '0);
		skip_rows(1); // jumped over when taken
	endtask

	task automatic load_case(input logic [2:0] f3, input int k);
		plain(i_inst(7'b0000011, f3, 5'd10, 5'd0, 12'h040 + 12'(k)));
		store_word(5'd10, load_expect(f3, ld_word >> (8 * k)));
	endtask

	task automatic build_program();
		word_t a;
		word_t b;
		word_t c;
		word_t r;
		word_t at;
		word_t handler;
		logic signed [11:0] simm;

		a = 32'hffff_fffb; // x3
		b = 32'd7;         // x4
		plain(u_inst(7'b0110111, 5'd1, 20'h12345));
		store_word(5'd1, 32'h1234_5000);
		at = here();
		plain(u_inst(7'b0010111, 5'd2, 20'h00001));
		store_word(5'd2, at + 32'h1000);
		plain(i_inst(7'b0010011, 3'b000, 5'd3, 5'd0, 12'hffb));
		store_word(5'd3, a);
		plain(i_inst(7'b0010011, 3'b000, 5'd4, 5'd0, 12'd7));
		alu_case(7'h00, 3'b000, a + b);
		alu_case(7'h20, 3'b000, a - b);
		alu_case(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
		alu_case(7'h00, 3'b011, {31'b0, a < b});
		alu_case(7'h00, 3'b111, a & b);
		alu_case(7'h00, 3'b110, a | b);
		alu_case(7'h00, 3'b100, a ^ b);
		alu_case(7'h00, 3'b001, a << b[4:0]);
		alu_case(7'h00, 3'b101, a >> b[4:0]);
		alu_case(7'h20, 3'b101, $signed(a) >>> b[4:0]);

		for (int k = 0; k < 8; k++) begin
			if (k != 2 && k != 3) begin
				branch_case(3'(k), 5'd3, 5'd4, a, b);
				branch_case(3'(k), 5'd4, 5'd3, b, a);
				branch_case(3'(k), 5'd4, 5'd4, b, b);
			end
		end

		at = here();
		put_row(j_inst(21'd12, 5'd6), at + 32'd12, 1'b0, '0, '0, '0);
		skip_rows(2);
		store_word(5'd6, at + 32'd4); // link
		at = here();
		plain(u_inst(7'b0010111, 5'd7, 20'h0));
		put_row(i_inst(7'b1100111, 3'b000, 5'd8, 5'd7, 12'd17),
			(at + 32'd17) & ~32'd1, 1'b0, '0, '0, '0); // odd target
		skip_rows(2);
		store_word(5'd8, at + 32'd8);

		c = 32'ha1b2_c3d4;
		plain(u_inst(7'b0110111, 5'd9, 20'ha1b2c));
		plain(i_inst(7'b0010011, 3'b000, 5'd9, 5'd9, 12'h3d4));
		for (int k = 0; k < 4; k++)
			put_row(s_inst(3'b000, 5'd0, 5'd9, 12'h100 + 12'(k)), here() + 32'd4, 1'b1,
				32'h100, c << (8 * k), 4'b0001 << k);
		for (int k = 0; k < 4; k += 2)
			put_row(s_inst(3'b001, 5'd0, 5'd9, 12'h100 + 12'(k)), here() + 32'd4, 1'b1,
				32'h100, c << (8 * k), 4'b0011 << k);

		ld_word = 32'h7f80_c06a;
		for (int k = 0; k < 4; k++) begin
			load_case(3'b000, k);
			load_case(3'b100, k);
		end
		for (int k = 0; k < 4; k += 2) begin
			load_case(3'b001, k);
			load_case(3'b101, k);
		end
		load_case(3'b010, 0);

		at = here();
		handler = at + 32'd32;
		plain(u_inst(7'b0010111, 5'd11, 20'h0));
		plain(i_inst(7'b0010011, 3'b000, 5'd11, 5'd11, 12'd32)); // x11 = handler
		plain(csr_inst(3'b001, 5'd12, 5'd11, CSR_MTVEC));
		store_word(5'd12, 32'h0);
		plain(csr_inst(3'b010, 5'd13, 5'd0, CSR_MTVEC));
		store_word(5'd13, handler);
		put_row(csr_inst(3'b000, 5'd0, 5'd0, 12'h000), handler, 1'b0, '0, '0, '0); // ecall
		put_row(j_inst(21'd32, 5'd0), at + 32'd60, 1'b0, '0, '0, '0); // resume after mret
		plain(csr_inst(3'b010, 5'd14, 5'd0, CSR_MCAUSE));
		store_word(5'd14, 32'd11);
		plain(csr_inst(3'b010, 5'd15, 5'd0, CSR_MEPC));
		plain(i_inst(7'b0010011, 3'b000, 5'd15, 5'd15, 12'd4));
		plain(csr_inst(3'b001, 5'd0, 5'd15, CSR_MEPC));
		store_word(5'd15, at + 32'd28);
		put_row(csr_inst(3'b000, 5'd0, 5'd0, 12'h302), at + 32'd28, 1'b0, '0, '0, '0); // mret

		for (int n = 0; n < 20; n++) begin
			a = $random(seed);
			r = $random(seed);
			simm = r[11:0];
			b = simm;
			r = (a + 32'h800) >> 12; // upper part compensates the signed low part
			plain(u_inst(7'b0110111, 5'd16, r[19:0]));
			plain(i_inst(7'b0010011, 3'b000, 5'd16, 5'd16, a[11:0]));
			plain(i_inst(7'b0010011, 3'b000, 5'd17, 5'd16, simm));
			store_word(5'd17, a + b);
			plain(r_inst(7'h00, 3'b000, 5'd18, 5'd16, 5'd17));
			store_word(5'd18, a + a + b);
		end
	endtask

	task automatic run_program(output bit done);
		word_t exp_pc;
		int    idx;
		int    cycles;
		int    limit;
		string where;
		exp_pc = RESET_PC;
		cycles = 0;
		done   = 1'b0;
		limit  = 2 * prog_inst.size() + 20;
		while (!done && cycles < limit) begin
			if (cycles > 0)
				@(negedge clk);
			check_word("pc", pc, exp_pc);
			where = $sformatf(" at pc %h", pc);
			idx = int'((pc - RESET_PC) >> 2);
			if (idx >= prog_inst.size()) begin
				done = 1'b1;
			end else begin
				inst   = prog_inst[idx];
				exp_pc = next_pc[idx];
				#1;
				check_flag({"mem_wen", where}, mem_wen, exp_st[idx]);
				if (exp_st[idx]) begin
					check_word({"mem_addr", where}, mem_addr, exp_addr[idx]);
					check_word({"mem_wdata", where}, mem_wdata, exp_data[idx]);
					check_mask({"mem_wmask", where}, mem_wmask, exp_mask[idx]);
				end
			end
			cycles++;
		end
	endtask

	initial begin
		seed  = 35508;
		reset = 1'b1;
		inst  = s_inst(3'b010, 5'd0, 5'd3, 12'h100); // store held during reset
		build_program();
		for (int i = 0; i < 128; i++)
			dmem[i] = fill_word(32'(i * 4));
		dmem[16] = ld_word; // 0x40
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1;
			check_word("pc during reset", pc, RESET_PC);
			check_flag("mem_wen during reset", mem_wen, 1'b0);
		end
		@(negedge clk);
		reset = 1'b0;
		run_program(finished);
		if (finished) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_with_failure("timeout: the program did not reach its last row");
		end
	end

endmodule

/* list.f */
verilog/rv_pkg.sv
verilog/rv_idu.sv
verilog/rv_exu.sv
verilog/rv_regfile.sv
verilog/rv_csr.sv
verilog/rv_lsu.sv
verilog/rv_ifu.sv
verilog/rv_core.sv
tb/rv_core_tb.sv
